// ==== src/spi_ctrl_defs.svh ====
// spi register-access controller constants
// bit-period divider and the command bytes sent as the first byte of a frame
`ifndef SPI_CTRL_DEFS_SVH
`define SPI_CTRL_DEFS_SVH

// log2 of the sck bit period in clk cycles
`define SPI_CLK_DIV 3

// first byte of each frame, as the slave decodes it
`define SPI_CMD_WRITE  8'h02	// cmd, addr, wdata
`define SPI_CMD_READ   8'h03	// cmd, addr, dummy
`define SPI_CMD_STATUS 8'h05	// cmd, dummy
`define SPI_CMD_ECHO   8'h9F	// cmd, byte_hi, byte_lo

// status returns the slave write counter
// echo returns 8'hA5 then the inverse of the second byte

// frame lengths in bytes, command byte included
`define SPI_LEN_SHORT 2'd2
`define SPI_LEN_LONG  2'd3

`endif

// ==== src/spi_cmd_pkg.sv ====
// host-side request and response types
// one request word in, one response word out per transaction
package spi_cmd_pkg;

	typedef enum logic [2:0] {
		OP_WRITE  = 3'd0,	// register write
		OP_READ   = 3'd1,	// register read
		OP_STATUS = 3'd2,	// slave status byte
		OP_ECHO   = 3'd3	// two raw bytes through the slave
	} spi_op_e;	// 4..7 are rejected by decode

	typedef struct packed {
		logic [7:0] addr;	// register address
		logic [7:0] wdata;	// write data, unused on read
	} spi_reg_view_t;

	typedef struct packed {
		logic [7:0] byte_hi;	// sent second
		logic [7:0] byte_lo;	// sent third
	} spi_raw_view_t;

	// same 16 bits, decoded per opcode
	typedef union packed {
		spi_reg_view_t reg_view;	// write and read
		spi_raw_view_t raw_view;	// echo
	} spi_payload_u;

	typedef struct packed {
		spi_op_e      op;
		spi_payload_u payload;
	} spi_req_t;	// 19 bits

	typedef struct packed {
		logic       err;	// illegal opcode, no frame sent
		logic [7:0] data0;	// first kept rx byte
		logic [7:0] data1;	// second kept rx byte, else zero
	} spi_rsp_t;	// 17 bits

endpackage

// ==== src/spi_bus_pkg.sv ====
// internal frame types between decode, execute and result
// a frame plan lists the bytes to send and which rx bytes to keep
package spi_bus_pkg;

	typedef struct packed {
		logic [1:0]      nbytes;	// 2 or 3, command byte included
		logic [2:0][7:0] tx_bytes;	// index 0 goes out first
		logic [2:0]      keep_mask;	// bit i keeps the rx byte of tx_bytes[i]
	} spi_plan_t;

	// set when decode rejected the request
	// the plan is then ignored and only a response is made
	typedef logic spi_err_t;

	// byte result handed from execute to the engine side
	typedef struct packed {
		logic [1:0] idx;	// position in the frame
		logic [7:0] rx;	// byte shifted in
	} spi_rx_beat_t;

endpackage

// ==== src/spi_req_decode.sv ====
// request decode stage
// one registered slot, turns a host request into a spi frame plan
`timescale 1ns/100ps
`include "spi_ctrl_defs.svh"

module spi_req_decode (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   req_valid,
	input  spi_cmd_pkg::spi_req_t  req,
	input  logic                   plan_ready,
	output logic                   req_ready,
	output logic                   plan_valid,
	output spi_bus_pkg::spi_plan_t plan,
	output spi_bus_pkg::spi_err_t  plan_err
);
	logic                   full_q;	// slot holds a plan
	logic                   take;	// request handshake
	spi_bus_pkg::spi_plan_t plan_d, plan_q;
	spi_bus_pkg::spi_err_t  err_d, err_q;

	assign req_ready  = !full_q || plan_ready;	// empty, or draining this cycle
	assign take       = req_valid && req_ready;
	assign plan_valid = full_q;
	assign plan       = plan_q;
	assign plan_err   = err_q;

	always_comb begin
		plan_d = '0;	// unused bytes go out as zero
		err_d  = 1'b0;
		case (req.op)
			spi_cmd_pkg::OP_WRITE: begin
				plan_d.nbytes      = `SPI_LEN_LONG;
				plan_d.tx_bytes[0] = `SPI_CMD_WRITE;
				plan_d.tx_bytes[1] = req.payload.reg_view.addr;
				plan_d.tx_bytes[2] = req.payload.reg_view.wdata;
			end
			spi_cmd_pkg::OP_READ: begin
				plan_d.nbytes      = `SPI_LEN_LONG;
				plan_d.tx_bytes[0] = `SPI_CMD_READ;
				plan_d.tx_bytes[1] = req.payload.reg_view.addr;
				plan_d.keep_mask   = 3'b100;	// data comes back in byte 3
			end
			spi_cmd_pkg::OP_STATUS: begin
				plan_d.nbytes      = `SPI_LEN_SHORT;
				plan_d.tx_bytes[0] = `SPI_CMD_STATUS;
				plan_d.keep_mask   = 3'b010;
			end
			spi_cmd_pkg::OP_ECHO: begin
				plan_d.nbytes      = `SPI_LEN_LONG;
				plan_d.tx_bytes[0] = `SPI_CMD_ECHO;
				plan_d.tx_bytes[1] = req.payload.raw_view.byte_hi;
				plan_d.tx_bytes[2] = req.payload.raw_view.byte_lo;
				plan_d.keep_mask   = 3'b110;
			end
			default: err_d = 1'b1;	// opcodes 4..7
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			full_q <= 1'b0;
		end else if (take) begin
			full_q <= 1'b1;	// refill wins over drain
		end else if (plan_ready) begin
			full_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			plan_q <= plan_d;
			err_q  <= err_d;
		end
	end

endmodule

// ==== src/spi_seq_exec.sv ====
// frame sequencer
// holds ss low over a whole frame, feeds the byte engine, gathers kept rx bytes
`timescale 1ns/100ps

module spi_seq_exec (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   plan_valid,
	input  spi_bus_pkg::spi_plan_t plan,
	input  spi_bus_pkg::spi_err_t  plan_err,
	input  logic                   eng_busy,
	input  logic                   eng_done,
	input  logic [7:0]             eng_rx,
	input  logic                   slot_ready,
	output logic                   plan_ready,
	output logic                   eng_start,
	output logic [7:0]             eng_tx,
	output logic                   ss,
	output logic                   slot_valid,
	output spi_cmd_pkg::spi_rsp_t  rsp
);
	typedef enum logic [2:0] {S_IDLE, S_WAIT_SLOT, S_BYTE, S_LAST, S_REPORT} state_e;

	state_e                 state_q;
	spi_bus_pkg::spi_plan_t plan_q;	// frame being run
	logic [1:0]             idx_q;	// byte in flight
	logic                   start_q;	// start pending for the engine
	logic                   ss_q;
	logic                   got0_q;	// data0 already filled
	logic                   err_q;
	logic [7:0]             d0_q, d1_q;
	logic                   take;
	logic                   in_frame;
	logic                   keep_now;

	assign plan_ready = (state_q == S_IDLE || state_q == S_WAIT_SLOT) && slot_ready;
	assign take       = plan_valid && plan_ready;
	assign in_frame   = (state_q == S_BYTE) || (state_q == S_LAST);
	assign keep_now   = in_frame && eng_done && plan_q.keep_mask[idx_q];
	assign eng_start  = start_q && !eng_busy;
	assign eng_tx     = plan_q.tx_bytes[idx_q];
	assign ss         = ss_q;
	assign slot_valid = (state_q == S_REPORT);	// one cycle after last done
	assign rsp.err    = err_q;
	assign rsp.data0  = d0_q;
	assign rsp.data1  = d1_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= S_IDLE;
			idx_q   <= '0;
			start_q <= 1'b0;
			ss_q    <= 1'b1;
			got0_q  <= 1'b0;
		end else begin
			if (eng_start)
				start_q <= 1'b0;	// engine took it
			if (keep_now)
				got0_q <= 1'b1;
			case (state_q)
				S_IDLE, S_WAIT_SLOT: begin
					if (take) begin
						idx_q  <= '0;
						got0_q <= 1'b0;
						if (plan_err) begin
							state_q <= S_REPORT;	// no bus traffic
						end else begin
							state_q <= S_BYTE;
							ss_q    <= 1'b0;
							start_q <= 1'b1;
						end
					end else begin
						state_q <= plan_valid ? S_WAIT_SLOT : S_IDLE;	// result slot still full
					end
				end
				S_BYTE: if (eng_done) begin
					idx_q   <= idx_q + 2'd1;
					start_q <= 1'b1;	// next byte right after done
					if (idx_q + 2'd2 == plan_q.nbytes)
						state_q <= S_LAST;
				end
				S_LAST: if (eng_done) begin
					ss_q    <= 1'b1;
					state_q <= S_REPORT;
				end
				S_REPORT: if (slot_ready) state_q <= S_IDLE;
				default: state_q <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			plan_q <= plan;
			err_q  <= plan_err;
			d0_q   <= '0;	// zero-fill bytes not kept
			d1_q   <= '0;
		end else if (keep_now) begin
			if (got0_q)
				d1_q <= eng_rx;
			else
				d0_q <= eng_rx;
		end
	end

endmodule

// ==== src/spi_byte_engine.sv ====
// full-duplex spi byte shifter, mode with sck idle low
// bit period is 2**CLK_DIV clocks, mosi launched at period start, miso sampled before sck falls
`timescale 1ns/100ps
`include "spi_ctrl_defs.svh"

module spi_byte_engine #(
	parameter int CLK_DIV = `SPI_CLK_DIV
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       start,
	input  logic [7:0] tx_byte,
	input  logic       miso,
	output logic       busy,
	output logic       done,
	output logic [7:0] rx_byte,
	output logic       sck,
	output logic       mosi
);
	typedef enum logic [1:0] {IDLE, WAIT_HALF, TRANSFER} state_e;

	localparam logic [CLK_DIV-1:0] PH_LAST    = '1;	// about to rise
	localparam logic [CLK_DIV-1:0] PH_HALF_M1 = PH_LAST >> 1;	// about to fall

	state_e             state_q, state_d;
	logic [CLK_DIV-1:0] ph_q, ph_d;	// phase within the bit period
	logic [2:0]         bit_q, bit_d;	// bit counter
	logic [7:0]         shreg_q, shreg_d;	// tx out the top, rx in the bottom
	logic               mosi_q, mosi_d;
	logic               done_q, done_d;
	logic [7:0]         rx_q, rx_d;

	assign sck     = ~ph_q[CLK_DIV-1] & (state_q == TRANSFER);	// high in first half
	assign busy    = (state_q != IDLE);
	assign mosi    = mosi_d;	// lines up with the sck rise
	assign done    = done_q;
	assign rx_byte = rx_q;

	always_comb begin
		state_d = state_q;
		ph_d    = ph_q;
		bit_d   = bit_q;
		shreg_d = shreg_q;
		mosi_d  = mosi_q;
		done_d  = 1'b0;	// single-cycle pulse
		rx_d    = rx_q;
		case (state_q)
			IDLE: begin
				ph_d   = '0;
				bit_d  = '0;
				mosi_d = 1'b0;	// park low between bytes
				if (start) begin
					shreg_d = tx_byte;
					state_d = WAIT_HALF;
				end
			end
			WAIT_HALF: begin
				ph_d = ph_q + 1'b1;
				if (ph_q == PH_HALF_M1) begin
					ph_d    = '0;	// lead-in of half a period
					state_d = TRANSFER;
				end
			end
			TRANSFER: begin
				ph_d = ph_q + 1'b1;
				if (ph_q == '0)
					mosi_d = shreg_q[7];	// msb first
				if (ph_q == PH_HALF_M1)
					shreg_d = {shreg_q[6:0], miso};
				if (ph_q == PH_LAST) begin
					bit_d = bit_q + 3'd1;
					if (bit_q == 3'd7) begin
						state_d = IDLE;
						rx_d    = shreg_q;
						done_d  = 1'b1;
					end
				end
			end
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= IDLE;
			ph_q    <= '0;
			bit_q   <= '0;
			mosi_q  <= 1'b0;
			done_q  <= 1'b0;
		end else begin
			state_q <= state_d;
			ph_q    <= ph_d;
			bit_q   <= bit_d;
			mosi_q  <= mosi_d;
			done_q  <= done_d;
		end
	end

	always_ff @(posedge clk) begin
		shreg_q <= shreg_d;
		rx_q    <= rx_d;
	end

endmodule

// ==== src/spi_resp_build.sv ====
// response slot
// one result word with a full flag, held steady until the host takes it
`timescale 1ns/100ps

module spi_resp_build (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  slot_valid,
	input  spi_cmd_pkg::spi_rsp_t rsp_in,
	input  logic                  rsp_ready,
	output logic                  slot_ready,
	output logic                  rsp_valid,
	output spi_cmd_pkg::spi_rsp_t rsp
);
	logic                  full_q;
	logic                  push;	// word in from the sequencer
	logic                  pop;	// word out to the host
	spi_cmd_pkg::spi_rsp_t rsp_q;

	// room when empty, or when the host drains it this cycle
	assign slot_ready = !full_q || rsp_ready;
	assign push       = slot_valid && slot_ready;
	assign pop        = full_q && rsp_ready;
	assign rsp_valid  = full_q;
	assign rsp        = rsp_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			full_q <= 1'b0;
		end else if (push) begin
			full_q <= 1'b1;	// drain and refill together keeps it full
		end else if (pop) begin
			full_q <= 1'b0;
		end
	end

	// only loads on push, so the word is stable under back-pressure
	always_ff @(posedge clk) begin
		if (push)
			rsp_q <= rsp_in;
	end

endmodule

// ==== src/spi_ctrl_top.sv ====
// spi register-access controller
// decode, frame sequencer, byte engine and response slot in a chain
`timescale 1ns/100ps
`include "spi_ctrl_defs.svh"

module spi_ctrl_top #(
	parameter int CLK_DIV = `SPI_CLK_DIV
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  req_valid,
	input  spi_cmd_pkg::spi_req_t req,
	input  logic                  rsp_ready,
	input  logic                  miso,
	output logic                  req_ready,
	output logic                  rsp_valid,
	output spi_cmd_pkg::spi_rsp_t rsp,
	output logic                  sck,
	output logic                  mosi,
	output logic                  ss
);
	logic                   plan_valid, plan_ready;
	spi_bus_pkg::spi_plan_t plan;
	spi_bus_pkg::spi_err_t  plan_err;
	logic                   eng_start, eng_busy, eng_done;
	logic [7:0]             eng_tx, eng_rx;
	logic                   slot_valid, slot_ready;
	spi_cmd_pkg::spi_rsp_t  slot_rsp;

	spi_req_decode i_req_decode (
		.clk(clk), .rst(rst),
		.req_valid(req_valid), .req(req), .req_ready(req_ready),
		.plan_valid(plan_valid), .plan(plan), .plan_err(plan_err), .plan_ready(plan_ready)
	);

	spi_seq_exec i_seq_exec (
		.clk(clk), .rst(rst),
		.plan_valid(plan_valid), .plan(plan), .plan_err(plan_err), .plan_ready(plan_ready),
		.eng_busy(eng_busy), .eng_done(eng_done), .eng_rx(eng_rx),
		.eng_start(eng_start), .eng_tx(eng_tx), .ss(ss),
		.slot_ready(slot_ready), .slot_valid(slot_valid), .rsp(slot_rsp)
	);

	spi_byte_engine #(.CLK_DIV(CLK_DIV)) i_byte_engine (
		.clk(clk), .rst(rst),
		.start(eng_start), .tx_byte(eng_tx), .miso(miso),
		.busy(eng_busy), .done(eng_done), .rx_byte(eng_rx),
		.sck(sck), .mosi(mosi)
	);

	spi_resp_build i_resp_build (
		.clk(clk), .rst(rst),
		.slot_valid(slot_valid), .rsp_in(slot_rsp), .slot_ready(slot_ready),
		.rsp_ready(rsp_ready), .rsp_valid(rsp_valid), .rsp(rsp)
	);

endmodule

// ==== dv/tb_clock_gen.sv ====
// testbench clock and reset source
// 8 ns clock, reset high for the first 3 cycles
`timescale 1ns/100ps

module tb_clock_gen (
	output logic clk,
	output logic rst
);
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;	// 8 ns period
	end

	initial begin
		rst = 1'b1;
		repeat (3) @(posedge clk);
		#1 rst = 1'b0;	// released off the edge, like the other inputs
	end

endmodule

// ==== dv/spi_slave_model.sv ====
// behavioral spi register slave
// 256-byte array, write counter, echo replies; samples on sck fall, drives on sck rise
`timescale 1ns/100ps
`include "spi_ctrl_defs.svh"

module spi_slave_model (
	input  logic ss,
	input  logic sck,
	input  logic mosi,
	output logic miso
);
	logic [7:0] mem [256];
	logic [7:0] wr_count;	// writes completed
	logic [2:0] bit_cnt;	// bit within the byte
	logic [1:0] byte_idx;	// byte within the frame
	logic [7:0] shift_in;
	logic [7:0] cmd;
	logic [7:0] addr;	// second byte, also the echo source
	logic [7:0] reply;	// byte being shifted out

	// byte driven back while byte idx is shifting
	function automatic logic [7:0] reply_byte(input logic [1:0] idx);
		logic [7:0] r;
		r = 8'h00;
		if (idx == 2'd1 && cmd == `SPI_CMD_ECHO)
			r = 8'hA5;
		else if (idx == 2'd1 && cmd == `SPI_CMD_STATUS)
			r = wr_count;
		else if (idx == 2'd2 && cmd == `SPI_CMD_READ)
			r = mem[addr];
		else if (idx == 2'd2 && cmd == `SPI_CMD_ECHO)
			r = ~addr;	// inverse of the second byte
		return r;
	endfunction

	initial begin
		for (int i = 0; i < 256; i++)
			mem[i] = i[7:0] ^ 8'h3C;	// fill depends on every address bit
		wr_count = '0;
		bit_cnt  = '0;
		byte_idx = '0;
		cmd      = '0;
		addr     = '0;
		shift_in = '0;
		reply    = '0;
		miso     = 1'b0;
	end

	always @(posedge ss or posedge sck or negedge sck) begin
		if (ss) begin
			bit_cnt  = '0;	// frame ends with ss high
			byte_idx = '0;
			miso     = 1'b0;
		end else if (sck) begin
			reply = reply_byte(byte_idx);
			miso  = reply[3'd7 - bit_cnt];	// msb first
		end else begin
			shift_in = {shift_in[6:0], mosi};
			if (bit_cnt == 3'd7) begin
				case (byte_idx)
					2'd0: cmd = shift_in;
					2'd1: addr = shift_in;
					default: if (cmd == `SPI_CMD_WRITE) begin
						mem[addr] = shift_in;
						wr_count  = wr_count + 8'd1;
					end
				endcase
				byte_idx = byte_idx + 2'd1;
			end
			bit_cnt = bit_cnt + 3'd1;
		end
	end

endmodule

// ==== dv/spi_ctrl_properties.sv ====
// protocol checks on the controller pins and handshakes
// bound onto the top level, failures go through $error
`timescale 1ns/100ps

module spi_ctrl_properties (
	input logic                  clk,
	input logic                  rst,
	input logic                  sck,
	input logic                  ss,
	input logic                  req_valid,
	input logic                  req_ready,
	input spi_cmd_pkg::spi_req_t req,
	input logic                  rsp_valid,
	input logic                  rsp_ready,
	input spi_cmd_pkg::spi_rsp_t rsp
);
	int fail_count = 0;	// read by the testbench

	sck_idle: assert property (@(posedge clk) disable iff (rst) ss |-> !sck)
		else begin $error("sck toggles while ss is high"); fail_count++; end

	reset_pins: assert property (@(posedge clk) $fell(rst) |-> (ss && !sck))
		else begin $error("ss or sck wrong after reset"); fail_count++; end

	rsp_hold: assert property (@(posedge clk) disable iff (rst)
		(rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp)))
		else begin $error("response changed under back-pressure"); fail_count++; end

	req_hold: assert property (@(posedge clk) disable iff (rst)
		(req_valid && !req_ready) |=> (req_valid && $stable(req)))
		else begin $error("request changed before it was taken"); fail_count++; end

endmodule

// ==== dv/spi_ctrl_tb.sv ====
// testbench for the spi register-access controller
// table of directed requests, then lcg requests against a mirror of the slave
`timescale 1ns/100ps
`include "spi_ctrl_defs.svh"

module spi_ctrl_tb;
	localparam int NUM_TABLE = 10;
	localparam int NUM_RAND  = 40;
	localparam int BIT_CYC   = 1 << `SPI_CLK_DIV;
	localparam int FRAME_CYC = 3 * (BIT_CYC / 2 + 8 * BIT_CYC) + 8;	// worst frame, 3 bytes
	localparam int TIMEOUT_NS = ((NUM_TABLE + NUM_RAND) * FRAME_CYC * 3 + 600) * 8;

	typedef struct packed {
		logic [2:0]  op;
		logic [15:0] payload;	// addr/wdata or byte_hi/byte_lo
		logic        err;
		logic [7:0]  d0;
		logic [7:0]  d1;
	} vec_t;

	logic clk, rst, miso, sck, mosi, ss;
	logic req_valid, req_ready, rsp_valid, rsp_ready;
	spi_cmd_pkg::spi_req_t req;
	spi_cmd_pkg::spi_rsp_t rsp;

	vec_t       vecs [NUM_TABLE];
	vec_t       exp_q [$];	// expected responses in request order
	logic [7:0] mirror [256];	// slave array as it should be
	logic [7:0] wr_cnt;
	logic [31:0] req_seed, rdy_seed;
	logic       hold_rsp;	// forces rsp_ready low
	int         errors, other_errors, frames, legal_frames, sent, received;

	tb_clock_gen i_clk_gen (.clk(clk), .rst(rst));

	spi_ctrl_top i_spi_ctrl_top (
		.clk(clk), .rst(rst),
		.req_valid(req_valid), .req(req), .req_ready(req_ready),
		.rsp_valid(rsp_valid), .rsp(rsp), .rsp_ready(rsp_ready),
		.sck(sck), .mosi(mosi), .ss(ss), .miso(miso)
	);

	spi_slave_model i_slave (.ss(ss), .sck(sck), .mosi(mosi), .miso(miso));

	bind spi_ctrl_top spi_ctrl_properties i_props (.*);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// expected response from the slave rules, updates the mirror on writes
	function automatic vec_t predict(input logic [2:0] op, input logic [15:0] payload);
		vec_t e;
		e = '0;
		e.op = op;
		e.payload = payload;
		case (op)
			3'd0: begin
				mirror[payload[15:8]] = payload[7:0];
				wr_cnt = wr_cnt + 8'd1;
			end
			3'd1: e.d0 = mirror[payload[15:8]];
			3'd2: e.d0 = wr_cnt;
			3'd3: begin
				e.d0 = 8'hA5;
				e.d1 = ~payload[15:8];
			end
			default: e.err = 1'b1;	// no frame expected
		endcase
		if (op < 3'd4)
			legal_frames++;
		return e;
	endfunction

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	// hold the request until the handshake edge, queue what should come back
	task automatic send(input logic [2:0] op, input logic [15:0] payload, input vec_t e);
		req       = spi_cmd_pkg::spi_req_t'({op, payload});
		req_valid = 1'b1;
		forever begin
			@(negedge clk);
			if (req_ready)
				break;
		end
		exp_q.push_back(e);
		@(posedge clk);
		#1 req_valid = 1'b0;
		sent++;
	endtask

	always @(negedge ss)
		if (!rst)
			frames++;

	// response side, rsp_ready from its own lcg stream
	initial begin
		vec_t e;
		forever begin
			@(posedge clk);
			#1;
			rdy_seed = lcg_next(rdy_seed);
			rsp_ready = !hold_rsp && (rdy_seed[16] || rdy_seed[17]);
			@(negedge clk);
			if (!rst && rsp_valid && rsp_ready) begin
				if (exp_q.size() == 0) begin
					other_errors++;
					$display("unexpected response at %0t ns with nothing outstanding", $time);
				end else begin
					e = exp_q.pop_front();
					check($sformatf("err op %0d", e.op), rsp.err, e.err);
					check($sformatf("data0 op %0d", e.op), rsp.data0, e.d0);
					check($sformatf("data1 op %0d", e.op), rsp.data1, e.d1);
				end
				received++;
			end
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("timeout: responses still missing after %0d ns", TIMEOUT_NS);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		vec_t e;
		logic [2:0] op;
		logic [15:0] payload;
		req_valid = 1'b0;
		req       = '0;
		rsp_ready = 1'b0;
		hold_rsp  = 1'b1;
		req_seed  = 32'h2969_7b60;
		rdy_seed  = lcg_next(32'h2969_7b60 ^ 32'h0000_ffff);
		wr_cnt    = '0;
		errors       = 0;
		other_errors = 0;
		frames       = 0;
		legal_frames = 0;
		sent         = 0;
		received     = 0;
		for (int i = 0; i < 256; i++)
			mirror[i] = i[7:0] ^ 8'h3C;
		//        op    payload    err  d0     d1
		vecs[0] = {3'd0, 16'h105C, 1'b0, 8'h00, 8'h00};
		vecs[1] = {3'd1, 16'h1000, 1'b0, 8'h5C, 8'h00};
		vecs[2] = {3'd2, 16'h0000, 1'b0, 8'h01, 8'h00};
		vecs[3] = {3'd3, 16'h3C81, 1'b0, 8'hA5, 8'hC3};
		vecs[4] = {3'd5, 16'h1234, 1'b1, 8'h00, 8'h00};
		vecs[5] = {3'd0, 16'hFF01, 1'b0, 8'h00, 8'h00};
		vecs[6] = {3'd2, 16'h0000, 1'b0, 8'h02, 8'h00};
		vecs[7] = {3'd1, 16'hFF00, 1'b0, 8'h01, 8'h00};
		vecs[8] = {3'd7, 16'hFFFF, 1'b1, 8'h00, 8'h00};
		vecs[9] = {3'd1, 16'h2000, 1'b0, 8'h1C, 8'h00};	// never written, fill value
		@(negedge rst);
		@(posedge clk);
		#1;
		for (int i = 0; i < NUM_TABLE; i++) begin
			e = predict(vecs[i].op, vecs[i].payload);	// keeps the mirror in step
			send(vecs[i].op, vecs[i].payload, vecs[i]);
			if (i == 1) begin
				wait (rsp_valid);	// first response parked in the slot
				repeat (100) @(posedge clk);	// slot and decode stay full meanwhile
				#1 hold_rsp = 1'b0;
			end
		end
		for (int i = 0; i < NUM_RAND; i++) begin
			req_seed = lcg_next(req_seed);
			if (req_seed[31:29] == 3'd7)
				op = 3'd4 + {1'b0, req_seed[1:0]};
			else
				op = {1'b0, req_seed[28:27]};
			payload = {4'h1, req_seed[3:0], req_seed[23:16]};	// small address range
			e = predict(op, payload);
			send(op, payload, e);
		end
		wait (received == sent);
		repeat (5) @(posedge clk);
		if (frames != legal_frames) begin
			other_errors++;
			$display("saw %0d spi frames but %0d legal requests were sent", frames, legal_frames);
		end
		other_errors += i_spi_ctrl_top.i_props.fail_count;
		$display("%0d requests, %0d mismatches, %0d other errors", sent, errors, other_errors);
		if (errors == 0 && other_errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== spi_ctrl_top.f ====
+incdir+src
src/spi_cmd_pkg.sv
src/spi_bus_pkg.sv
src/spi_req_decode.sv
src/spi_seq_exec.sv
src/spi_byte_engine.sv
src/spi_resp_build.sv
src/spi_ctrl_top.sv
dv/tb_clock_gen.sv
dv/spi_slave_model.sv
dv/spi_ctrl_properties.sv
dv/spi_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the SPI controller testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f spi_ctrl_top.f --top-module spi_ctrl_tb \
	--Mdir obj_dir -o sim_spi_ctrl
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_spi_ctrl > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TESTBENCH PASSED" "$LOG"; then
	exit 0
fi
echo "pass line not found in $LOG"
exit 1
